/* dv/fetch_patterns.hex */
// @00 counts: memory words, redirects, records
// @04 memory: word address (5 digits) _ data word
// @18 redirects: after record index _ cs _ ip
// @20 records: opcode _ imm _ ip _ len
@00
12 2 13
@04
7fff8_4090 7fff9_12b0 7fffa_34b8 7fffb_eb12 7fffc_e805
7fffd_abcd 7fffe_43f4 7ffff_78bb 00000_9056
09220_48b8 09221_efb9 09222_41be 09223_00e9 09224_4a10
00100_ffb7 00101_bf90 00102_8001 00103_90c3
@18
09_1234_0101 0e_0000_0200
@20
90_0000_0000_1 40_0000_0001_1 b0_0012_0002_2 b8_1234_0004_3
eb_0005_0007_2 e8_abcd_0009_3 f4_0000_000c_1 43_0000_000d_1
bb_5678_000e_3 90_0000_0011_1
48_0000_0101_1 b9_beef_0102_3 41_0000_0105_1 e9_1000_0106_3
4a_0000_0109_1
b7_00ff_0200_2 90_0000_0202_1 bf_8001_0203_3 c3_0000_0206_1

/* fetch_frontend.f */
verilog/bus_pkg.sv
verilog/instr_pkg.sv
verilog/byte_fifo.sv
verilog/prefetch_unit.sv
verilog/immediate_reader.sv
verilog/fetch_sequencer.sv
verilog/fetch_frontend.sv
dv/fetch_frontend_checker.sv
dv/fetch_frontend_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module fetch_frontend_tb \
    -f fetch_frontend.f -Mdir obj_dir

status=0
./obj_dir/Vfetch_frontend_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0

/* dv/fetch_frontend_tb.sv */
// Testbench for the fetch front end
// Bus memory model with random ack delay, plus redirects and
// record checks driven from the pattern file.
module fetch_frontend_tb
    import bus_pkg::*;
    import instr_pkg::*;
();

    localparam int mem_base = 'h04;
    localparam int redir_base = 'h18;
    localparam int rec_base = 'h20;
    localparam int valid_timeout = 200;

    logic       clk;
    logic       rst_n;
    logic       redirect;
    far_ptr_t   redirect_target;
    word_addr_t instr_m_addr;
    bus_word_t  instr_m_data;
    logic       instr_m_access;
    logic       instr_m_ack;
    logic       instr_valid;
    instr_t     instr;

    logic [63:0] pat [0:63];
    int          n_mem;
    int          n_redir;
    int          n_rec;
    integer      seed = 90;
    int          instr_errors;
    int          addr_errors;
    int          other_errors;
    int          fetch_no;

    // Bus model state
    far_ptr_t exp_ptr;
    logic     in_cycle;
    logic     stale;
    logic [1:0] ack_delay;

    fetch_frontend #(
        .fifo_depth(6)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect       (redirect),
        .redirect_target(redirect_target),
        .instr_m_addr   (instr_m_addr),
        .instr_m_data   (instr_m_data),
        .instr_m_access (instr_m_access),
        .instr_m_ack    (instr_m_ack),
        .instr_valid    (instr_valid),
        .instr          (instr)
    );

    always #5 clk = ~clk;

    // Word address of cs * 16 + ip modulo 1 MB
    function automatic word_addr_t phys_word(far_ptr_t p);
        int unsigned phys;
        phys = (32'(p.cs) * 16 + 32'(p.ip)) % 32'h0010_0000;
        return word_addr_t'(phys >> 1);
    endfunction

    // Image word if present, else a fill from the whole address
    function automatic bus_word_t mem_word(word_addr_t a);
        logic [18:0] v;
        bus_word_t   w;
        v = a;
        w = v[15:0] ^ {2{5'h0, v[18:16]}};
        for (int i = 0; i < n_mem; i++) begin
            if (pat[mem_base + i][34:16] == v) begin
                w = pat[mem_base + i][15:0];
            end
        end
        return w;
    endfunction

    function automatic instr_t unpack_record(logic [63:0] e);
        return '{opcode: e[43:36], imm: e[35:20], ip: e[19:4], len: e[1:0]};
    endfunction

    task automatic check_instr(string name, instr_t exp, instr_t act);
        if (act !== exp) begin
            instr_errors++;
            $display("[ERROR] %s expected op=%h imm=%h ip=%h len=%0d", name,
                     exp.opcode, exp.imm, exp.ip, exp.len);
            $display("[ERROR] %s actual   op=%h imm=%h ip=%h len=%0d", name,
                     act.opcode, act.imm, act.ip, act.len);
        end
    endtask

    task automatic check_addr(string name, word_addr_t exp, word_addr_t act);
        if (act !== exp) begin
            addr_errors++;
            $display("[ERROR] %s expected addr=%h actual addr=%h", name, exp, act);
        end
    endtask

    // Instruction bus memory that acks 0 to 3 cycles late
    always @(posedge clk) begin
        if (!rst_n) begin
            in_cycle = 1'b0;
            stale = 1'b0;
            exp_ptr = '{cs: reset_cs, ip: reset_ip};
        end else begin
            if (instr_m_access && instr_m_ack) begin
                if (!stale && !redirect) begin
                    exp_ptr.ip = (exp_ptr.ip | 16'd1) + 16'd1;
                end
                in_cycle = 1'b0;
            end else if (instr_m_access && !in_cycle) begin
                check_addr($sformatf("fetch %0d", fetch_no), phys_word(exp_ptr),
                           instr_m_addr);
                fetch_no++;
                in_cycle = 1'b1;
                stale = 1'b0;
                ack_delay = 2'($random(seed));
            end
            if (redirect) begin
                // Fetch in flight is dropped by the DUT
                stale = in_cycle;
                exp_ptr = redirect_target;
            end
        end
        #1;
        if (in_cycle && ack_delay == 2'd0) begin
            instr_m_ack = 1'b1;
            instr_m_data = mem_word(instr_m_addr);
        end else begin
            instr_m_ack = 1'b0;
            if (in_cycle) begin
                ack_delay = ack_delay - 2'd1;
            end
        end
    end

    initial begin
        int     rec_idx;
        int     redir_idx;
        int     waited;
        logic   timed_out;
        instr_t exp;
        clk = 1'b0;
        rst_n = 1'b0;
        redirect = 1'b0;
        redirect_target = '0;
        instr_m_ack = 1'b0;
        instr_m_data = '0;
        $readmemh("dv/fetch_patterns.hex", pat);
        n_mem = int'(pat[0]);
        n_redir = int'(pat[1]);
        n_rec = int'(pat[2]);
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        redir_idx = 0;
        timed_out = 1'b0;
        for (rec_idx = 0; rec_idx < n_rec && !timed_out; rec_idx++) begin
            exp = unpack_record(pat[rec_base + rec_idx]);
            if (exp.len != imm_len_of(exp.opcode) + 2'd1) begin
                other_errors++;
                $display("Pattern record %0d has a length that does not fit its opcode",
                         rec_idx);
            end
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!instr_valid && waited < valid_timeout);
            if (!instr_valid) begin
                timed_out = 1'b1;
                other_errors++;
                $display("Timed out waiting for record %0d", rec_idx);
            end else begin
                check_instr($sformatf("record %0d", rec_idx), exp, instr);
                // Redirect right after this record
                if (redir_idx < n_redir &&
                    int'(pat[redir_base + redir_idx][39:32]) == rec_idx) begin
                    #1;
                    redirect = 1'b1;
                    redirect_target = pat[redir_base + redir_idx][31:0];
                    @(posedge clk);
                    #1 redirect = 1'b0;
                    redir_idx++;
                end
            end
        end

        repeat (2) @(posedge clk);
        $display("Errors: record %0d, address %0d, other %0d",
                 instr_errors, addr_errors, other_errors);
        if (instr_errors + addr_errors + other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* dv/fetch_frontend_checker.sv */
// Bus and record strobe assertions for the fetch front end
// Bound into fetch_frontend.
module fetch_frontend_checker
    import bus_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       redirect,
    input logic       instr_m_access,
    input logic       instr_m_ack,
    input word_addr_t instr_m_addr,
    input logic       instr_valid
);

    // Access held with a stable address until ack
    a_access_hold: assert property (@(posedge clk) disable iff (!rst_n)
        instr_m_access && !instr_m_ack |=> instr_m_access && $stable(instr_m_addr))
        else $error("instr_m_access dropped or address changed before ack");

    // Access drops for a cycle after ack
    a_access_gap: assert property (@(posedge clk) disable iff (!rst_n)
        instr_m_access && instr_m_ack |=> !instr_m_access)
        else $error("instr_m_access still high after ack");

    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !instr_m_access)
        else $error("instr_m_access high after reset");

    // No record rises on the edge that takes the redirect
    a_valid_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !instr_valid)
        else $error("instr_valid rose at a redirect");

endmodule

bind fetch_frontend fetch_frontend_checker checker0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect      (redirect),
    .instr_m_access(instr_m_access),
    .instr_m_ack   (instr_m_ack),
    .instr_m_addr  (instr_m_addr),
    .instr_valid   (instr_valid)
);

/* verilog/fetch_frontend.sv */
// Instruction fetch front end
// Prefetcher, byte queue, immediate reader and fetch sequencer.
module fetch_frontend
    import bus_pkg::*;
    import instr_pkg::*;
#(
    parameter int fifo_depth = 6
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       redirect,
    input  far_ptr_t   redirect_target,
    output word_addr_t instr_m_addr,
    input  bus_word_t  instr_m_data,
    output logic       instr_m_access,
    input  logic       instr_m_ack,
    output logic       instr_valid,
    output instr_t     instr
);

    logic     fifo_wr_en;
    opcode_t  fifo_wr_data;
    logic     fifo_rd_en;
    opcode_t  fifo_rd_data;
    logic     fifo_empty;
    logic     fifo_nearly_full;
    logic     seq_rd_en;
    logic     imm_rd_en;
    logic     imm_start;
    imm_len_t imm_count;
    logic     imm_complete;
    imm_t     imm;

    // Sequencer and reader never pop together
    assign fifo_rd_en = seq_rd_en | imm_rd_en;

    byte_fifo #(
        .fifo_depth(fifo_depth)
    ) fifo0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (redirect),
        .wr_en      (fifo_wr_en),
        .wr_data    (fifo_wr_data),
        .rd_en      (fifo_rd_en),
        .rd_data    (fifo_rd_data),
        .empty      (fifo_empty),
        .nearly_full(fifo_nearly_full)
    );

    prefetch_unit #(
        .fifo_depth(fifo_depth)
    ) prefetch0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .instr_m_addr    (instr_m_addr),
        .instr_m_data    (instr_m_data),
        .instr_m_access  (instr_m_access),
        .instr_m_ack     (instr_m_ack),
        .fifo_wr_en      (fifo_wr_en),
        .fifo_wr_data    (fifo_wr_data),
        .fifo_nearly_full(fifo_nearly_full)
    );

    immediate_reader imm_reader0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (redirect),
        .start       (imm_start),
        .count       (imm_count),
        .busy        (),
        .complete    (imm_complete),
        .imm         (imm),
        .fifo_rd_en  (imm_rd_en),
        .fifo_rd_data(fifo_rd_data),
        .fifo_empty  (fifo_empty)
    );

    fetch_sequencer sequencer0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_ip (redirect_target.ip),
        .fifo_rd_en  (seq_rd_en),
        .fifo_rd_data(fifo_rd_data),
        .fifo_empty  (fifo_empty),
        .imm_start   (imm_start),
        .imm_count   (imm_count),
        .imm_complete(imm_complete),
        .imm         (imm),
        .instr_valid (instr_valid),
        .instr       (instr)
    );

endmodule

/* verilog/fetch_sequencer.sv */
// Fetch sequencer
// Reads opcodes from the prefetch queue, starts immediate reads,
// tracks the instruction IP and emits one record per instruction.
module fetch_sequencer
    import bus_pkg::*;
    import instr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     redirect,
    input  offset_t  redirect_ip,
    output logic     fifo_rd_en,
    input  opcode_t  fifo_rd_data,
    input  logic     fifo_empty,
    output logic     imm_start,
    output imm_len_t imm_count,
    input  logic     imm_complete,
    input  imm_t     imm,
    output logic     instr_valid,
    output instr_t   instr
);

    typedef enum logic [1:0] {
        sq_opcode,
        sq_imm_wait,
        sq_emit
    } sq_state_t;

    sq_state_t  state;
    imm_len_t   imm_len;
    offset_t    instr_ip;
    opcode_t    opcode_q;
    imm_t       imm_q;
    logic [1:0] len_q;

    assign imm_len = imm_len_of(fifo_rd_data);

    // No pop in a redirect cycle while the queue is flushed
    assign fifo_rd_en = (state == sq_opcode) && !fifo_empty && !redirect;
    assign imm_start = fifo_rd_en && (imm_len != '0);
    assign imm_count = imm_len;

    // A record pending at a redirect belongs to the old stream
    assign instr_valid = (state == sq_emit) && !redirect;
    assign instr = '{opcode: opcode_q, imm: imm_q, ip: instr_ip, len: len_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= sq_opcode;
            instr_ip <= reset_ip;
        end else if (redirect) begin
            state <= sq_opcode;
            instr_ip <= redirect_ip;
        end else begin
            case (state)
                sq_opcode: begin
                    if (fifo_rd_en) begin
                        state <= imm_start ? sq_imm_wait : sq_emit;
                    end
                end
                sq_imm_wait: begin
                    if (imm_complete) begin
                        state <= sq_emit;
                    end
                end
                default: begin
                    state <= sq_opcode;
                    instr_ip <= instr_ip + offset_t'(len_q);
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd_en) begin
            opcode_q <= fifo_rd_data;
            imm_q <= '0;
            len_q <= imm_len + 2'd1;
        end
        if (state == sq_imm_wait && imm_complete) begin
            imm_q <= imm;
        end
    end

endmodule

/* verilog/immediate_reader.sv */
// Immediate reader
// Pops one or two bytes from the prefetch queue and builds a
// little-endian immediate, zero-extended for a single byte.
module immediate_reader
    import instr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     start,
    input  imm_len_t count,
    output logic     busy,
    output logic     complete,
    output imm_t     imm,
    output logic     fifo_rd_en,
    input  opcode_t  fifo_rd_data,
    input  logic     fifo_empty
);

    imm_len_t remaining;
    logic     hi_byte;

    assign fifo_rd_en = busy && (remaining != '0) && !fifo_empty;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            busy <= 1'b0;
            complete <= 1'b0;
            remaining <= '0;
            hi_byte <= 1'b0;
        end else begin
            complete <= (fifo_rd_en && remaining == 2'd1) || (start && count == '0);
            if (start) begin
                busy <= 1'b1;
                remaining <= count;
                hi_byte <= 1'b0;
            end else begin
                if (fifo_rd_en) begin
                    remaining <= remaining - 1'b1;
                    hi_byte <= 1'b1;
                end
                // Busy drops after the complete cycle
                if (complete) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            imm <= '0;
        end else if (fifo_rd_en) begin
            if (hi_byte) begin
                imm[15:8] <= fifo_rd_data;
            end else begin
                imm[7:0] <= fifo_rd_data;
            end
        end
    end

endmodule

/* verilog/prefetch_unit.sv */
// Instruction prefetcher
// Fetches 16-bit words at CS:IP over the instruction bus and
// pushes the bytes into the prefetch queue, low byte first.
module prefetch_unit
    import bus_pkg::*;
    import instr_pkg::*;
#(
    parameter int fifo_depth = 6
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       redirect,
    input  far_ptr_t   redirect_target,
    output word_addr_t instr_m_addr,
    input  bus_word_t  instr_m_data,
    output logic       instr_m_access,
    input  logic       instr_m_ack,
    output logic       fifo_wr_en,
    output opcode_t    fifo_wr_data,
    input  logic       fifo_nearly_full
);

    typedef enum logic [1:0] {
        pf_idle,
        pf_fetch,
        pf_wr_lo,
        pf_wr_hi
    } pf_state_t;

    pf_state_t   state;
    far_ptr_t    fetch_ptr;
    bus_word_t   staging;
    logic        discard;
    logic [19:0] phys_addr;

    // Queue must hold a full word plus room for the readers
    if (fifo_depth < 4) begin : g_depth_check
        $error("prefetch_unit needs fifo_depth of at least 4");
    end

    // cs * 16 + ip modulo 1 MB
    assign phys_addr = {fetch_ptr.cs, 4'h0} + {4'h0, fetch_ptr.ip};

    assign instr_m_access = (state == pf_fetch);
    assign fifo_wr_en = (state == pf_wr_lo) || (state == pf_wr_hi);
    assign fifo_wr_data = (state == pf_wr_lo) ? staging[7:0] : staging[15:8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= pf_idle;
            fetch_ptr <= '{cs: reset_cs, ip: reset_ip};
            discard <= 1'b0;
        end else begin
            if (redirect) begin
                fetch_ptr <= redirect_target;
            end
            case (state)
                pf_idle: begin
                    if (!fifo_nearly_full && !redirect) begin
                        state <= pf_fetch;
                    end
                end
                pf_fetch: begin
                    if (instr_m_ack) begin
                        discard <= 1'b0;
                        if (discard || redirect) begin
                            state <= pf_idle;
                        end else begin
                            // Odd IP skips the byte at the even address
                            state <= fetch_ptr.ip[0] ? pf_wr_hi : pf_wr_lo;
                            fetch_ptr.ip <= {fetch_ptr.ip[15:1] + 15'd1, 1'b0};
                        end
                    end else if (redirect) begin
                        // Let the bus cycle finish and drop its data
                        discard <= 1'b1;
                    end
                end
                pf_wr_lo: begin
                    state <= redirect ? pf_idle : pf_wr_hi;
                end
                default: begin
                    state <= pf_idle;
                end
            endcase
        end
    end

    // Address is latched while idle so it holds for the whole access
    always_ff @(posedge clk) begin
        if (state == pf_idle) begin
            instr_m_addr <= phys_addr[19:1];
        end
        if (instr_m_access && instr_m_ack) begin
            staging <= instr_m_data;
        end
    end

endmodule

/* verilog/byte_fifo.sv */
// Prefetch byte queue
// Circular buffer with occupancy count, flush and a nearly-full
// flag raised when fewer than two entries are free.
module byte_fifo
    import instr_pkg::*;
#(
    parameter int fifo_depth = 6
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,
    input  logic    wr_en,
    input  opcode_t wr_data,
    input  logic    rd_en,
    output opcode_t rd_data,
    output logic    empty,
    output logic    nearly_full
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    opcode_t          mem [fifo_depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_wr = wr_en && (count != cnt_w'(fifo_depth));
    assign do_rd = rd_en && !empty;

    assign rd_data = mem[rd_ptr];
    assign empty = (count == '0);
    assign nearly_full = (count >= cnt_w'(fifo_depth - 1));

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* verilog/instr_pkg.sv */
// Opcode, immediate and decoded instruction types
// Also holds the immediate length rule per opcode.
package instr_pkg;

    import bus_pkg::*;

    typedef logic [7:0] opcode_t;
    typedef logic [15:0] imm_t;

    // Number of immediate bytes, 0 to 2
    typedef logic [1:0] imm_len_t;

    // One record per instruction with len counting the opcode byte too
    typedef struct packed {
        opcode_t    opcode;
        imm_t       imm;
        offset_t    ip;
        logic [1:0] len;
    } instr_t;

    function automatic imm_len_t imm_len_of(opcode_t op);
        imm_len_t len;
        case (op) inside
            // MOV r8, imm8 and short JMP
            [8'hb0:8'hb7], 8'heb: begin
                len = 2'd1;
            end
            // MOV r16, imm16, CALL and near JMP
            [8'hb8:8'hbf], 8'he8, 8'he9: begin
                len = 2'd2;
            end
            default: begin
                len = 2'd0;
            end
        endcase
        return len;
    endfunction

endpackage

/* verilog/bus_pkg.sv */
// Instruction bus and CS:IP address types
// Shared by the prefetcher, the sequencer and the top level.
package bus_pkg;

    // Bits 19:1 of the 20-bit physical address
    typedef logic [19:1] word_addr_t;

    typedef logic [15:0] bus_word_t;

    typedef logic [15:0] seg_t;
    typedef logic [15:0] offset_t;

    // Far pointer, used as the redirect target and the fetch pointer
    typedef struct packed {
        seg_t    cs;
        offset_t ip;
    } far_ptr_t;

    // Pointer after reset
    localparam seg_t    reset_cs = 16'hffff;
    localparam offset_t reset_ip = 16'h0000;

endpackage
